//--- f_permutation.sv
// Iterative Keccak-f[1600] with absorb, one round per clock.
// A block is taken when in_ready is high and no rounds are running. ack pulses
// in that cycle. The block is XORed into the top rate bits before round 0.
// out_ready falls on the accept edge and rises 24 edges later. out is only
// stable while out_ready is high.
`timescale 1ns/10ps
`default_nettype none

module f_permutation (
    input  wire                                clk,
    input  wire                                reset,
    input  wire  [keccak_pkg::rate_width-1:0]  in,
    input  wire                                in_ready,
    output logic                               ack,
    output logic [keccak_pkg::state_width-1:0] out,
    output logic                               out_ready
);
    import keccak_pkg::*;

    logic [num_rounds-1:0]  i;                       // One-hot position of the next round
    logic                   calc;                    // High while rounds 1 to 23 remain
    logic                   accept;                  // Block taken this cycle
    logic                   update;                  // State register enable
    logic [state_width-1:0] round_in;
    logic [state_width-1:0] round_out;
    logic [63:0]            rc;

    assign accept = in_ready & ~calc;                // Idle and a block is waiting
    assign update = calc | accept;
    assign ack    = accept;                          // Padder drops its block on this edge

    // Absorb step. The capacity part is passed through untouched
    assign round_in = accept ? {in ^ out[state_width-1 -: rate_width], out[capacity_width-1:0]}
                             : out;

    always_ff @(posedge clk) begin
        if (reset) begin
            i <= '0;
        end else begin
            i <= {i[num_rounds-2:0], accept};        // Accept strobe walks through the rounds
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            calc <= 1'b0;
        end else begin
            calc <= (calc & ~i[num_rounds-2]) | accept; // Ends on the edge of round 23
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b0;
        end else if (accept) begin
            out_ready <= 1'b0;                       // New block makes the old state invalid
        end else if (i[num_rounds-1]) begin
            out_ready <= 1'b1;                       // One edge after the final round landed
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;                               // Sponge starts from the zero state
        end else if (update) begin
            out <= round_out;
        end
    end

    // Round 0 is selected by the accept strobe itself
    keccak_rconst rconst_i (
        .i  ({i[num_rounds-2:0], accept}),
        .rc (rc)
    );

    keccak_round round_i (
        .in  (round_in),
        .rc  (rc),
        .out (round_out)
    );

endmodule

`default_nettype wire

//--- keccak_padder.sv
// Collects 64-bit message words into 576-bit blocks and applies SHA3 padding.
// A word is taken when in_ready is high and buffer_full is low.
// The word flagged is_last keeps byte_num bytes (0 to 7) and is always padded
// in place, so a message that is a multiple of 8 bytes needs an empty last word.
// block_ready holds until ack, and no words are taken meanwhile.
`timescale 1ns/10ps
`default_nettype none

module keccak_padder (
    input  wire                               clk,
    input  wire                               reset,
    input  wire  [keccak_pkg::word_width-1:0] in,
    input  wire                               in_ready,
    input  wire                               is_last,
    input  wire  [2:0]                        byte_num,
    output logic                              buffer_full,
    output logic [keccak_pkg::rate_width-1:0] block,
    output logic                              block_ready,
    output logic                              last_block,
    input  wire                               ack
);
    import keccak_pkg::*;

    logic [words_per_block-1:0] cnt;                 // One-hot count of words already held
    logic                       done;                // Padded final block waits for ack
    logic                       take;                // Word accepted this cycle
    logic [word_width-1:0]      keep_mask;           // Valid message bytes of the last word
    logic [word_width-1:0]      pad_word;            // Last word with 0x06 appended
    logic [rate_width-1:0]      shifted;             // Block with the padded word shifted in
    logic [rate_width-1:0]      padded_block;        // Final block ready to hand over

    assign buffer_full = block_ready;                // Only stall source is a waiting block
    assign take        = in_ready & ~buffer_full;
    assign last_block  = done;

    always_comb begin
        keep_mask = ~({word_width{1'b1}} >> (8 * byte_num)); // Top byte_num bytes kept
        pad_word  = (in & keep_mask)
                  | (word_width'(8'h06) << (word_width - 8 - 8 * byte_num)); // 0x06 after message
        shifted   = {block[rate_width-word_width-1:0], pad_word};

        // Move the held words to the top of the block and zero-fill below them
        padded_block = '0;
        for (int j = 0; j < words_per_block; j++) begin
            if (cnt[j]) begin
                padded_block = shifted << (word_width * (words_per_block - 1 - j));
            end
        end
        padded_block[7:0] = padded_block[7:0] | 8'h80; // Closing pad bit, gives 0x86 if shared
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt         <= words_per_block'(1);      // Empty buffer
            block       <= '0;
            block_ready <= 1'b0;
            done        <= 1'b0;
        end else if (ack) begin
            block_ready <= 1'b0;                     // Permutation has latched the block
            done        <= 1'b0;
        end else if (take) begin
            if (is_last) begin
                block       <= padded_block;         // Padding completes the block at once
                cnt         <= words_per_block'(1);
                block_ready <= 1'b1;
                done        <= 1'b1;
            end else begin
                block       <= {block[rate_width-word_width-1:0], in}; // First word ends on top
                cnt         <= {cnt[words_per_block-2:0], cnt[words_per_block-1]};
                block_ready <= cnt[words_per_block-1]; // Ninth word fills the block
            end
        end
    end

endmodule

`default_nettype wire

//--- keccak_pkg.sv
// Shared sizes for the SHA3-512 core.
// Only the 576-bit rate of SHA3-512 is supported. Other SHA3 and SHAKE widths are not.
// Message words are 64 bits, and the first message byte sits in the top byte of a word.
`default_nettype none

package keccak_pkg;

    // Keccak-f[1600] state split into the absorbed rate and the hidden capacity
    localparam int state_width = 1600;               // Full permutation state
    localparam int rate_width = 576;                 // Block absorbed per permutation call
    localparam int capacity_width = state_width - rate_width; // 1024 bits never touched by input

    localparam int word_width = 64;                  // Input word size
    localparam int words_per_block = rate_width / word_width; // Nine words fill one block

    localparam int num_rounds = 24;                  // Rounds of Keccak-f[1600]

    localparam int digest_width = 512;               // Upper state bits form the digest

endpackage

`default_nettype wire

//--- keccak_rconst.sv
// Round constant lookup for the iota step.
// The round index must be one-hot. Each set bit ORs in its own constant, so a
// word with several bits set gives a meaningless constant.
// Constants are in standard lane order (bit 0 is the lane LSB).
`timescale 1ns/10ps
`default_nettype none

module keccak_rconst (
    input  wire  [keccak_pkg::num_rounds-1:0] i,
    output logic [63:0]                       rc
);
    import keccak_pkg::*;

    function automatic logic [63:0] round_constant(input int r);
        case (r)                                     // Standard Keccak-f[1600] iota table
            0:       return 64'h0000_0000_0000_0001;
            1:       return 64'h0000_0000_0000_8082;
            2:       return 64'h8000_0000_0000_808A;
            3:       return 64'h8000_0000_8000_8000;
            4:       return 64'h0000_0000_0000_808B;
            5:       return 64'h0000_0000_8000_0001;
            6:       return 64'h8000_0000_8000_8081;
            7:       return 64'h8000_0000_0000_8009;
            8:       return 64'h0000_0000_0000_008A;
            9:       return 64'h0000_0000_0000_0088;
            10:      return 64'h0000_0000_8000_8009;
            11:      return 64'h0000_0000_8000_000A;
            12:      return 64'h0000_0000_8000_808B;
            13:      return 64'h8000_0000_0000_008B;
            14:      return 64'h8000_0000_0000_8089;
            15:      return 64'h8000_0000_0000_8003;
            16:      return 64'h8000_0000_0000_8002;
            17:      return 64'h8000_0000_0000_0080;
            18:      return 64'h0000_0000_0000_800A;
            19:      return 64'h8000_0000_8000_000A;
            20:      return 64'h8000_0000_8000_8081;
            21:      return 64'h8000_0000_0000_8080;
            22:      return 64'h0000_0000_8000_0001;
            23:      return 64'h8000_0000_8000_8008;
            default: return 64'h0;                   // Out of range rounds add nothing
        endcase
    endfunction

    always_comb begin
        rc = '0;                                     // No round selected gives a zero constant
        for (int r = 0; r < num_rounds; r++) begin
            if (i[r]) begin
                rc = rc | round_constant(r);         // OR of the selected entries
            end
        end
    end

endmodule

`default_nettype wire

//--- keccak_round.sv
// One combinational Keccak-f[1600] round: theta, rho, pi, chi and iota.
// Lane n (x + 5y) sits at state bits [1599-64n -: 64] with its bytes in message
// order, first byte on top. Lanes are byte-swapped to standard order on entry
// and swapped back on exit, so the results match the published SHA3 vectors.
// The round constant is expected in standard lane order.
`timescale 1ns/10ps
`default_nettype none

module keccak_round (
    input  wire  [keccak_pkg::state_width-1:0] in,
    input  wire  [63:0]                        rc,
    output logic [keccak_pkg::state_width-1:0] out
);
    import keccak_pkg::*;

    logic [63:0] a [25];                             // Input lanes in standard order
    logic [63:0] c [5];                              // Column parities
    logic [63:0] d [5];                              // Theta column corrections
    logic [63:0] t [25];                             // Lanes after theta
    logic [63:0] b [25];                             // Lanes after rho and pi
    logic [63:0] e [25];                             // Lanes after chi and iota

    // Reverses the byte order inside one lane
    function automatic logic [63:0] swap_bytes(input logic [63:0] w);
        logic [63:0] s;
        for (int k = 0; k < 8; k++) begin
            s[8*k +: 8] = w[56-8*k +: 8];
        end
        return s;
    endfunction

    function automatic logic [63:0] rol(input logic [63:0] v, input int s);
        logic [127:0] dbl;
        dbl = {v, v} << s;                           // Upper half holds the rotated lane
        return dbl[127:64];
    endfunction

    // Rho offsets indexed by lane number x + 5y
    function automatic int rho_offset(input int n);
        case (n)
            0:  return 0;   1:  return 1;   2:  return 62;  3:  return 28;  4:  return 27;
            5:  return 36;  6:  return 44;  7:  return 6;   8:  return 55;  9:  return 20;
            10: return 3;   11: return 10;  12: return 43;  13: return 25;  14: return 39;
            15: return 41;  16: return 45;  17: return 15;  18: return 21;  19: return 8;
            20: return 18;  21: return 2;   22: return 61;  23: return 56;  24: return 14;
            default: return 0;
        endcase
    endfunction

    always_comb begin
        for (int n = 0; n < 25; n++) begin
            a[n] = swap_bytes(in[state_width-1-64*n -: 64]); // Lane 0 is the top word
        end

        for (int x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20]; // Parity of column x
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rol(c[(x+1)%5], 1);  // Left neighbour plus rotated right one
        end
        for (int n = 0; n < 25; n++) begin
            t[n] = a[n] ^ d[n%5];                    // Theta applies per column
        end

        // Rho rotates each lane, pi moves lane (x,y) to (y, 2x+3y)
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                b[y + 5*((2*x + 3*y) % 5)] = rol(t[x + 5*y], rho_offset(x + 5*y));
            end
        end

        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]); // Chi along rows
            end
        end
        e[0] = e[0] ^ rc;                            // Iota touches lane (0,0) only

        for (int n = 0; n < 25; n++) begin
            out[state_width-1-64*n -: 64] = swap_bytes(e[n]); // Back to message byte order
        end
    end

endmodule

`default_nettype wire

//--- keccak_top.sv
// SHA3-512 core. Feed 64-bit words whenever buffer_full is low; a word is taken
// on each edge with in_ready high and buffer_full low.
// After the is_last word, send nothing until out_ready is high. The digest on
// out stays valid with out_ready until the first word of the next message.
// Only a single squeeze block is produced, so only SHA3-512 is covered.
`timescale 1ns/10ps
`default_nettype none

module keccak_top (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [keccak_pkg::word_width-1:0]   in,
    input  wire                                 in_ready,
    input  wire                                 is_last,
    input  wire  [2:0]                          byte_num,
    output logic                                buffer_full,
    output logic [keccak_pkg::digest_width-1:0] out,
    output logic                                out_ready
);
    import keccak_pkg::*;

    logic [rate_width-1:0]  block;                   // Padded block from the padder
    logic                   block_ready;
    logic                   last_block;              // Waiting block closes the message
    logic                   ack;
    logic [state_width-1:0] state;                   // Permutation state
    logic                   perm_ready;              // Permutation finished its rounds
    logic                   last_in_flight;          // Final block has entered the permutation
    logic                   take;

    assign take = in_ready & ~buffer_full;           // Same acceptance rule as the padder

    always_ff @(posedge clk) begin
        if (reset) begin
            last_in_flight <= 1'b0;
        end else if (ack & last_block) begin
            last_in_flight <= 1'b1;                  // Digest follows once these rounds end
        end else if (take) begin
            last_in_flight <= 1'b0;                  // First word of a new message
        end
    end

    assign out_ready = perm_ready & last_in_flight;  // Intermediate blocks never flag a digest
    assign out       = state[state_width-1 -: digest_width];

    keccak_padder padder_i (
        .clk         (clk),
        .reset       (reset),
        .in          (in),
        .in_ready    (in_ready),
        .is_last     (is_last),
        .byte_num    (byte_num),
        .buffer_full (buffer_full),
        .block       (block),
        .block_ready (block_ready),
        .last_block  (last_block),
        .ack         (ack)
    );

    f_permutation perm_i (
        .clk       (clk),
        .reset     (reset),
        .in        (block),
        .in_ready  (block_ready),
        .ack       (ack),
        .out       (state),
        .out_ready (perm_ready)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SHA3-512 testbench with Verilator, runs it and checks the log.

rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/10ps -f sources.f --top-module tb_keccak \
    -o sim_keccak > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_keccak > sim.log 2>&1 ; cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

//--- sources.f
keccak_pkg.sv
keccak_rconst.sv
keccak_round.sv
f_permutation.sv
keccak_padder.sv
keccak_top.sv
tb_keccak.sv

//--- tb_keccak.sv
// Testbench for the SHA3-512 core, driven from a table of messages and published digests.
// The core never clears its sponge state on its own. Each message therefore starts from a reset.
// Inputs change 2 ns after a rising edge, and outputs are sampled at that same point.
// Idle gaps of 0 to 3 cycles before the words of a first block come from a 16-bit Galois LFSR.
// Later blocks are sent back to back, so they fill up while the rounds run and meet buffer_full.
`timescale 1ns/10ps
`default_nettype none

module tb_keccak;

    localparam int num_entries = 3;
    localparam int ready_edges = 1 + 24;             // Accept edge, then one edge per round

    // Byte i of a message is text_head byte i below text_len, otherwise fill_byte
    localparam int          msg_len   [num_entries] = '{0, 3, 200};
    localparam int          text_len  [num_entries] = '{0, 3, 0};
    localparam logic [63:0] text_head [num_entries] = '{64'h0, 64'h6162_6300_0000_0000, 64'h0};
    localparam logic [7:0]  fill_byte [num_entries] = '{8'h00, 8'h00, 8'hA3};

    localparam logic [511:0] exp_digest [num_entries] = '{
        {256'ha69f73cc_a23a9ac5_c8b567dc_185a756e_97c98216_4fe25859_e0d1dcc1_475c80a6,
         256'h15b2123a_f1f5f94c_11e3e940_2c3ac558_f500199d_95b6d3e3_01758586_281dcd26},
        {256'hb751850b_1a57168a_5693cd92_4b6b096e_08f62182_7444f70d_884f5d02_40d2712e,
         256'h10e116e9_192af3c9_1a7ec576_47e39340_57340b4c_f408d5a5_6592f827_4eec53f0},
        {256'he76dfad2_2084a8b1_467fcf2f_fa58361b_ec7628ed_f5f3fdc0_e4805dc4_8caeeca8,
         256'h1b7c13c3_0adf52a3_65958473_9a2df46b_e589c51c_a1a4a841_6df6545a_1ce8ba00}
    };

    logic         clk;
    logic         reset;
    logic [63:0]  din;
    logic         in_ready;
    logic         is_last;
    logic [2:0]   byte_num;
    logic         buffer_full;
    logic [511:0] digest;
    logic         out_ready;

    logic [15:0]  lfsr = 16'd23651;                  // Gap generator state
    int           errors = 0;
    int           longest_wait = 0;                  // Most edges one word waited on buffer_full

    keccak_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .in          (din),
        .in_ready    (in_ready),
        .is_last     (is_last),
        .byte_num    (byte_num),
        .buffer_full (buffer_full),
        .out         (digest),
        .out_ready   (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                      // 40 ns period
    end

    task automatic check_value(input logic [511:0] got, input logic [511:0] expected,
                               input string what);
        if (got !== expected) begin
            errors++;
            $display("FAILED at time %0t: %s (got %0h, expected %0h)", $time, what, got, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int k = 0; k < n; k++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic [7:0] msg_byte(input int e, input int idx);
        if (idx < text_len[e]) begin
            return text_head[e][63-8*idx -: 8];
        end
        return fill_byte[e];
    endfunction

    // Word w of message e, first byte on top. Bytes past the end are junk the core must drop
    function automatic logic [63:0] make_word(input int e, input int w);
        logic [63:0] word;
        int          idx;
        word = '0;
        for (int b = 0; b < 8; b++) begin
            idx = 8 * w + b;
            word[63-8*b -: 8] = (idx < msg_len[e]) ? msg_byte(e, idx) : 8'h5A;
        end
        return word;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        int words;
        total = 0;
        for (int e = 0; e < num_entries; e++) begin
            words = msg_len[e] / 8 + 1;              // Always one last word, maybe empty
            total += words + 30 * ((words + 8) / 9); // Feeding plus rounds for every block
            total += 3 * words + 20;                 // Worst gaps, reset and hold cycles
        end
        return total + 100;
    endfunction

    task automatic apply_reset();
        reset    = 1'b1;
        din      = '0;
        in_ready = 1'b0;
        is_last  = 1'b0;
        byte_num = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value(512'(out_ready), 512'(1'b0), "out_ready high after reset");
        check_value(512'(buffer_full), 512'(1'b0), "buffer_full high after reset");
    endtask

    // Holds the word until an edge with buffer_full low takes it, returns 2 ns after that edge
    task automatic send_word(input logic [63:0] word, input logic last, input logic [2:0] nbytes);
        logic taken;
        int   waited;
        taken    = 1'b0;
        waited   = 0;
        din      = word;
        in_ready = 1'b1;
        is_last  = last;
        byte_num = nbytes;
        while (!taken) begin
            taken = !buffer_full;                    // Decides what the coming edge does
            if (!taken) begin
                waited++;                            // This edge leaves the word waiting
            end
            check_value(512'(out_ready), 512'(1'b0), "out_ready high while a message is sent");
            @(posedge clk);
            #2;
        end
        if (waited > longest_wait) begin
            longest_wait = waited;
        end
        in_ready = 1'b0;
        is_last  = 1'b0;
        byte_num = '0;
    endtask

    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("Timeout after %0d cycles: the digest never appeared", watchdog_cycles());
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int   n_words;
        int   n_blocks;
        int   gap;
        int   edges;
        logic last;
        logic full_expected;

        reset    = 1'b1;                             // All DUT inputs start defined
        din      = '0;
        in_ready = 1'b0;
        is_last  = 1'b0;
        byte_num = '0;

        for (int e = 0; e < num_entries; e++) begin
            apply_reset();
            n_words      = msg_len[e] / 8 + 1;
            n_blocks     = (n_words + 8) / 9;
            longest_wait = 0;

            for (int w = 0; w < n_words; w++) begin
                if (w < 9) begin
                    gap = random_bits(2);            // Random gaps inside the first block
                end else begin
                    gap = 0;                         // Next block fills while the rounds run
                end
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
                last = (w == n_words - 1);
                send_word(make_word(e, w), last, last ? 3'(msg_len[e] % 8) : 3'd0);
                full_expected = last || (w % 9 == 8); // Ninth word or padding closes a block
                check_value(512'(buffer_full), 512'(full_expected), "buffer_full after a word");
            end

            if (n_blocks > 1) begin                  // A full block must wait for busy rounds
                check_value(512'(longest_wait > 1), 512'(1'b1),
                            "no word held back by buffer_full while the rounds ran");
            end

            edges = 0;
            while (!out_ready) begin                 // Watchdog catches a digest that never comes
                @(posedge clk);
                #2;
                edges++;
            end
            if (n_blocks == 1) begin
                check_value(512'(edges), 512'(ready_edges), "out_ready rise latency");
            end
            check_value(digest, exp_digest[e], "digest mismatch");

            repeat (3) begin                         // Digest holds while no new word comes
                @(posedge clk);
                #2;
                check_value(512'(out_ready), 512'(1'b1), "out_ready dropped while idle");
                check_value(digest, exp_digest[e], "digest changed while idle");
            end

            check_value(512'(buffer_full), 512'(1'b0), "buffer_full high after the digest");
            din      = 64'h0123_4567_89AB_CDEF;      // First word of a following message
            in_ready = 1'b1;
            @(posedge clk);
            #2;
            in_ready = 1'b0;
            check_value(512'(out_ready), 512'(1'b0), "out_ready kept after a new first word");
        end

        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
